/* ps2_rx.f */
ps2_pkg.sv
ps2_line_sync.sv
ps2_frame_ctrl.sv
ps2_data_shifter.sv
ps2_scan_fifo.sv
ps2_rx.sv
tb_ps2_rx.sv

/* run.sh */
#!/usr/bin/env bash
# Build the PS/2 receiver testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ps2_rx -f ps2_rx.f \
    || { echo "Verilator build failed"; exit 1; }
sim_out="$(./obj_dir/Vtb_ps2_rx 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "TB PASSED" && exit 0 || exit 1

/* tb_ps2_rx.sv */
`timescale 1ns/1ps

module tb_ps2_rx;

    localparam int DRIVE_DELAY     = 10;
    localparam int SETUP_CYCLES    = 8;    // Data settles before the clock falls.
    localparam int HALF_CYCLES     = 16;
    localparam int BIT_CYCLES      = SETUP_CYCLES + 2 * HALF_CYCLES;
    localparam int GLITCH_AT       = 8;
    localparam int GLITCH_LEN      = ps2_pkg::FILTER_LEN - 1;
    localparam int POP_WAIT        = 4 * BIT_CYCLES;
    localparam int STALL_HOLD      = ps2_pkg::STALL_CYCLES + 100;
    localparam int N_RANDOM        = 20;
    localparam int N_BAD           = 3;
    localparam int N_BURST         = 10;
    localparam int N_GLITCH        = 3;
    localparam int TOTAL_FRAMES    = N_RANDOM + 2 * N_BAD + N_BURST + 2 + N_GLITCH;
    localparam int RUN_CYCLES      = TOTAL_FRAMES * 11 * BIT_CYCLES + STALL_HOLD;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + RUN_CYCLES / 5;

    logic                 clk;
    logic                 arst_n;
    logic                 ps2_clk;
    logic                 ps2_data;
    logic                 pop;
    ps2_pkg::scan_byte_t  rd_data;
    logic                 empty;
    logic                 overflow;
    logic                 frame_error;
    logic                 stall_abort;
    ps2_pkg::fifo_count_t count;

    ps2_pkg::scan_byte_t exp_q[$];    // Expected FIFO contents, oldest first.
    logic                exp_overflow;
    logic [15:0]         lfsr_q;
    string               test_name;
    int                  errors;
    int                  checks;
    int                  popped;
    int                  fe_pulses;
    int                  stall_pulses;
    int                  tests_run;
    int                  tests_failed;
    int                  test_start_errors;

    ps2_rx ps2_rx_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .pop         (pop),
        .rd_data     (rd_data),
        .empty       (empty),
        .overflow    (overflow),
        .frame_error (frame_error),
        .stall_abort (stall_abort),
        .count       (count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic odd_parity_bit(input ps2_pkg::scan_byte_t data);
        return ~(^data);
    endfunction

    // Bit 0 goes out first: start, data LSB first, parity, stop.
    function automatic logic [10:0] frame_bits(input ps2_pkg::scan_byte_t data,
                                               input bit bad_parity, input bit low_stop);
        logic par;
        par = odd_parity_bit(data) ^ bad_parity;
        return {~low_stop, par, data, 1'b0};
    endfunction

    // A frame is kept when the stop bit is high and data plus parity has odd weight.
    function automatic bit frame_accepted(input logic [10:0] bits);
        return bits[10] && (^bits[9:1]);
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic draw_byte(output ps2_pkg::scan_byte_t value);
        int i;
        value = '0;
        for (i = 0; i < 8; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = {lfsr_q[0], value[7:1]};
        end
    endtask

    task automatic check_eq(input string what, input int exp_val, input int act_val);
        checks++;
        assert (act_val == exp_val) else begin
            $display("ERROR %s %s: expected %0d, actual %0d", test_name, what, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == test_start_errors) begin
            $display("Test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", test_name, errors - test_start_errors);
        end
    endtask

    // Device side of the bus; an optional glitch lands in each clock phase.
    task automatic drive_bits(input logic [10:0] bits, input int n_bits, input bit glitch);
        int i;
        for (i = 0; i < n_bits; i++) begin
            ps2_data = bits[i];
            wait_cycles(SETUP_CYCLES);
            ps2_clk = 1'b0;
            if (glitch) begin
                wait_cycles(GLITCH_AT);
                ps2_clk = 1'b1;
                wait_cycles(GLITCH_LEN);
                ps2_clk = 1'b0;
                wait_cycles(HALF_CYCLES - GLITCH_AT - GLITCH_LEN);
            end else begin
                wait_cycles(HALF_CYCLES);
            end
            ps2_clk = 1'b1;
            if (glitch) begin
                wait_cycles(GLITCH_AT);
                ps2_clk = 1'b0;
                wait_cycles(GLITCH_LEN);
                ps2_clk = 1'b1;
                wait_cycles(HALF_CYCLES - GLITCH_AT - GLITCH_LEN);
            end else begin
                wait_cycles(HALF_CYCLES);
            end
        end
        ps2_data = 1'b1;    // Line idles high.
    endtask

    task automatic send_frame(input ps2_pkg::scan_byte_t data, input bit bad_parity,
                              input bit low_stop, input bit glitch);
        logic [10:0] bits;
        bits = frame_bits(data, bad_parity, low_stop);
        if (frame_accepted(bits)) begin
            if (exp_q.size() < ps2_pkg::FIFO_DEPTH) begin
                exp_q.push_back(data);
            end else begin
                exp_overflow = 1'b1;
            end
        end
        drive_bits(bits, 11, glitch);
    endtask

    task automatic pop_byte();
        int waited;
        waited = 0;
        while (empty && waited < POP_WAIT) begin
            wait_cycles(1);
            waited++;
        end
        if (empty) begin
            $display("No byte arrived within %0d cycles in test %s", POP_WAIT, test_name);
            errors++;
        end else begin
            pop = 1'b1;
            wait_cycles(1);
            pop = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && frame_error) begin
            fe_pulses++;
        end
        if (arst_n && stall_abort) begin
            stall_pulses++;
        end
    end

    // Every byte that leaves the FIFO is checked against the model.
    always @(negedge clk) begin : compare_pop
        ps2_pkg::scan_byte_t expected;
        if (arst_n && pop && !empty) begin
            if (exp_q.size() == 0) begin
                $display("Byte %02h popped in test %s but none was expected", rd_data, test_name);
                errors++;
            end else begin
                expected = exp_q.pop_front();
                popped++;
                checks++;
                assert (rd_data == expected) else begin
                    $display("ERROR %s popped byte: expected %02h, actual %02h",
                             test_name, expected, rd_data);
                    errors++;
                end
            end
        end
    end

    initial begin : main
        ps2_pkg::scan_byte_t b;
        logic [10:0]         bits;
        int                  i;
        int                  fe_before;
        int                  st_before;
        int                  popped_before;

        arst_n       = 1'b0;
        ps2_clk      = 1'b1;
        ps2_data     = 1'b1;
        pop          = 1'b0;
        lfsr_q       = 16'd63298;
        exp_overflow = 1'b0;
        errors       = 0;
        checks       = 0;
        popped       = 0;
        fe_pulses    = 0;
        stall_pulses = 0;
        tests_run    = 0;
        tests_failed = 0;
        wait_cycles(4);
        arst_n = 1'b1;
        wait_cycles(4);

        start_test("random_bytes");
        fe_before     = fe_pulses;
        popped_before = popped;
        for (i = 0; i < N_RANDOM; i++) begin
            draw_byte(b);
            send_frame(b, 1'b0, 1'b0, 1'b0);
            pop_byte();
        end
        wait_cycles(2);
        check_eq("bytes popped", N_RANDOM, popped - popped_before);
        check_eq("frame_error pulses", fe_before, fe_pulses);
        check_eq("count", 0, count);
        finish_test();

        start_test("bad_frames");
        for (i = 0; i < 2 * N_BAD; i++) begin
            draw_byte(b);
            fe_before = fe_pulses;
            send_frame(b, i < N_BAD, i >= N_BAD, 1'b0);    // Parity first, then stop.
            check_eq("frame_error pulses", fe_before + 1, fe_pulses);
            check_eq("count", 0, count);
        end
        finish_test();

        start_test("overflow");
        check_eq("overflow before burst", 0, overflow);
        for (i = 0; i < N_BURST; i++) begin
            draw_byte(b);
            send_frame(b, 1'b0, 1'b0, 1'b0);
        end
        check_eq("count", ps2_pkg::FIFO_DEPTH, count);
        check_eq("overflow", exp_overflow, overflow);
        popped_before = popped;
        for (i = 0; i < ps2_pkg::FIFO_DEPTH; i++) begin
            pop_byte();
        end
        wait_cycles(2);
        check_eq("bytes drained", ps2_pkg::FIFO_DEPTH, popped - popped_before);
        check_eq("count after drain", 0, count);
        check_eq("bytes left in model", 0, exp_q.size());
        finish_test();

        start_test("stall");
        st_before = stall_pulses;
        fe_before = fe_pulses;
        draw_byte(b);
        bits = frame_bits(b, 1'b0, 1'b0);
        drive_bits(bits, 5, 1'b0);    // Start bit and four data bits.
        wait_cycles(STALL_HOLD);
        check_eq("stall_abort pulses", st_before + 1, stall_pulses);
        check_eq("count after stall", 0, count);
        draw_byte(b);
        send_frame(b, 1'b0, 1'b0, 1'b0);
        pop_byte();
        wait_cycles(2);
        check_eq("frame_error pulses", fe_before, fe_pulses);
        check_eq("bytes left in model", 0, exp_q.size());
        finish_test();

        start_test("clock_glitch");
        fe_before     = fe_pulses;
        popped_before = popped;
        for (i = 0; i < N_GLITCH; i++) begin
            draw_byte(b);
            send_frame(b, 1'b0, 1'b0, 1'b1);
            pop_byte();
        end
        wait_cycles(2);
        check_eq("bytes popped", N_GLITCH, popped - popped_before);
        check_eq("frame_error pulses", fe_before, fe_pulses);
        finish_test();

        start_test("pop_empty");
        popped_before = popped;
        check_eq("empty before pop", 1, empty);
        pop = 1'b1;
        wait_cycles(1);
        pop = 1'b0;
        wait_cycles(2);
        check_eq("count", 0, count);
        check_eq("empty after pop", 1, empty);
        check_eq("bytes popped", 0, popped - popped_before);
        finish_test();

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* ps2_rx.sv */
`timescale 1ns/1ps

module ps2_rx (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 ps2_clk,
    input  logic                 ps2_data,
    input  logic                 pop,
    output ps2_pkg::scan_byte_t  rd_data,
    output logic                 empty,
    output logic                 overflow,
    output logic                 frame_error,
    output logic                 stall_abort,
    output ps2_pkg::fifo_count_t count
);

    ps2_pkg::line_sample_t sample;
    ps2_pkg::scan_byte_t   byte_out;
    logic                  clear;
    logic                  shift_en;
    logic                  parity_en;
    logic                  parity_ok;
    logic                  push;

    ps2_line_sync u_line_sync (
        .clk      (clk),
        .arst_n   (arst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .sample   (sample)
    );

    ps2_frame_ctrl u_frame_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .sample      (sample),
        .parity_ok   (parity_ok),
        .clear       (clear),
        .shift_en    (shift_en),
        .parity_en   (parity_en),
        .push        (push),
        .frame_error (frame_error),
        .stall_abort (stall_abort)
    );

    ps2_data_shifter u_data_shifter (
        .clk       (clk),
        .arst_n    (arst_n),
        .sample    (sample),
        .clear     (clear),
        .shift_en  (shift_en),
        .parity_en (parity_en),
        .byte_out  (byte_out),
        .parity_ok (parity_ok)
    );

    // Push lands long after the last shift, so byte_out is settled.
    ps2_scan_fifo u_scan_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (push),
        .wr_data  (byte_out),
        .pop      (pop),
        .rd_data  (rd_data),
        .empty    (empty),
        .count    (count),
        .overflow (overflow)
    );

endmodule

/* ps2_scan_fifo.sv */
`timescale 1ns/1ps

module ps2_scan_fifo (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 push,
    input  ps2_pkg::scan_byte_t  wr_data,
    input  logic                 pop,
    output ps2_pkg::scan_byte_t  rd_data,
    output logic                 empty,
    output ps2_pkg::fifo_count_t count,
    output logic                 overflow
);

    ps2_pkg::scan_byte_t  mem [ps2_pkg::FIFO_DEPTH];
    ps2_pkg::fifo_ptr_t   wr_ptr;
    ps2_pkg::fifo_ptr_t   rd_ptr;
    logic                 full;
    logic                 do_push;
    logic                 do_pop;

    function automatic ps2_pkg::fifo_ptr_t ptr_inc(input ps2_pkg::fifo_ptr_t ptr);
        if (ptr == ps2_pkg::fifo_ptr_t'(ps2_pkg::FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == ps2_pkg::fifo_count_t'(ps2_pkg::FIFO_DEPTH));
    assign do_push = push && !full;         // Full means the byte is lost.
    assign do_pop  = pop && !empty;
    assign rd_data = mem[rd_ptr];           // Head shows through.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && full) begin
                overflow <= 1'b1;           // Sticky until reset.
            end
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
        count <= ps2_pkg::fifo_count_t'(ps2_pkg::FIFO_DEPTH)
    );

    // A push behind a waiting head must not disturb it.
    a_head_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (!empty && !pop) |=> $stable(rd_data)
    );

endmodule

/* ps2_data_shifter.sv */
`timescale 1ns/1ps

module ps2_data_shifter (
    input  logic                  clk,
    input  logic                  arst_n,
    input  ps2_pkg::line_sample_t sample,
    input  logic                  clear,
    input  logic                  shift_en,
    input  logic                  parity_en,
    output ps2_pkg::scan_byte_t   byte_out,
    output logic                  parity_ok
);

    ps2_pkg::scan_byte_t shift_q;
    logic                par_acc;

    // LSB arrives first, so shifting in at the top leaves it in bit 0.
    always_ff @(posedge clk) begin
        if (clear) begin
            shift_q <= '0;
        end else if (shift_en) begin
            shift_q <= {sample.bit_val, shift_q[ps2_pkg::BYTE_W-1:1]};
        end
    end

    // Odd parity over data and parity bits.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            par_acc <= 1'b0;
        end else if (clear) begin
            par_acc <= 1'b0;
        end else if (shift_en || parity_en) begin
            par_acc <= par_acc ^ sample.bit_val;
        end
    end

    assign byte_out  = shift_q;
    assign parity_ok = par_acc;

endmodule

/* ps2_frame_ctrl.sv */
`timescale 1ns/1ps

module ps2_frame_ctrl (
    input  logic                  clk,
    input  logic                  arst_n,
    input  ps2_pkg::line_sample_t sample,
    input  logic                  parity_ok,
    output logic                  clear,
    output logic                  shift_en,
    output logic                  parity_en,
    output logic                  push,
    output logic                  frame_error,
    output logic                  stall_abort
);

    ps2_pkg::frame_state_t state;
    ps2_pkg::bit_idx_t     bit_idx;
    ps2_pkg::stall_cnt_t   stall_cnt;
    logic                  stalled;

    assign stalled = (state != ps2_pkg::ST_IDLE) &&
                     (stall_cnt == ps2_pkg::stall_cnt_t'(ps2_pkg::STALL_CYCLES));

    // Cycles since the last device clock edge.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stall_cnt <= '0;
        end else if (sample.fall_stb || state == ps2_pkg::ST_IDLE) begin
            stall_cnt <= '0;
        end else if (!stalled) begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= ps2_pkg::ST_IDLE;
            bit_idx     <= '0;
            clear       <= 1'b0;
            shift_en    <= 1'b0;
            parity_en   <= 1'b0;
            push        <= 1'b0;
            frame_error <= 1'b0;
            stall_abort <= 1'b0;
        end else begin
            // All controls are single-cycle pulses.
            clear       <= 1'b0;
            shift_en    <= 1'b0;
            parity_en   <= 1'b0;
            push        <= 1'b0;
            frame_error <= 1'b0;
            stall_abort <= 1'b0;

            if (stalled && !sample.fall_stb) begin
                state       <= ps2_pkg::ST_IDLE;
                stall_abort <= 1'b1;
            end else if (sample.fall_stb) begin
                case (state)
                    ps2_pkg::ST_IDLE: begin
                        if (!sample.bit_val) begin     // Start bit.
                            clear   <= 1'b1;
                            bit_idx <= '0;
                            state   <= ps2_pkg::ST_DATA;
                        end
                    end
                    ps2_pkg::ST_DATA: begin
                        shift_en <= 1'b1;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == ps2_pkg::bit_idx_t'(7)) begin
                            state <= ps2_pkg::ST_PARITY;
                        end
                    end
                    ps2_pkg::ST_PARITY: begin
                        parity_en <= 1'b1;
                        state     <= ps2_pkg::ST_STOP;
                    end
                    ps2_pkg::ST_STOP: begin
                        if (sample.bit_val && parity_ok) begin
                            push <= 1'b1;
                        end else begin
                            frame_error <= 1'b1;        // Bad parity or low stop bit.
                        end
                        state <= ps2_pkg::ST_IDLE;
                    end
                    default: begin
                        state <= ps2_pkg::ST_IDLE;
                    end
                endcase
            end
        end
    end

    // A frame ends exactly one way.
    a_push_xor_error: assert property (
        @(posedge clk) disable iff (!arst_n) !(push && frame_error)
    );

    // Data and parity edges never coincide.
    a_shift_parity_excl: assert property (
        @(posedge clk) disable iff (!arst_n) !(shift_en && parity_en)
    );

endmodule

/* ps2_line_sync.sv */
`timescale 1ns/1ps

module ps2_line_sync (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  ps2_clk,
    input  logic                  ps2_data,
    output ps2_pkg::line_sample_t sample
);

    logic                  clk_meta;
    logic                  clk_sync;
    logic                  data_meta;
    logic                  data_sync;
    logic                  clk_filt;
    ps2_pkg::filter_cnt_t  filt_cnt;
    logic                  filt_done;

    // Both lines idle high, so the synchronizers reset to 1.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_meta  <= 1'b1;
            clk_sync  <= 1'b1;
            data_meta <= 1'b1;
            data_sync <= 1'b1;
        end else begin
            clk_meta  <= ps2_clk;
            clk_sync  <= clk_meta;
            data_meta <= ps2_data;
            data_sync <= data_meta;
        end
    end

    // Last of FILTER_LEN samples that disagree with the filtered level.
    assign filt_done = (clk_sync != clk_filt) &&
                       (filt_cnt == ps2_pkg::filter_cnt_t'(ps2_pkg::FILTER_LEN - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_filt <= 1'b1;
            filt_cnt <= '0;
        end else if (clk_sync == clk_filt) begin
            filt_cnt <= '0;                 // Glitch ended early.
        end else if (filt_done) begin
            clk_filt <= clk_sync;
            filt_cnt <= '0;
        end else begin
            filt_cnt <= filt_cnt + 1'b1;
        end
    end

    // Strobe lines up with clk_filt going low; bit_val holds until the next edge.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sample <= '0;
        end else begin
            sample.fall_stb <= filt_done && clk_filt;
            if (filt_done && clk_filt) begin
                sample.bit_val <= data_sync;
            end
        end
    end

endmodule

/* ps2_pkg.sv */
package ps2_pkg;

    localparam int BYTE_W       = 8;
    localparam int FIFO_DEPTH   = 8;
    localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);
    localparam int FILTER_LEN   = 4;    // Equal samples before a new clock level is taken.
    localparam int FILTER_CNT_W = $clog2(FILTER_LEN);
    localparam int STALL_CYCLES = 2000; // Idle clk cycles before a frame is abandoned.
    localparam int STALL_CNT_W  = $clog2(STALL_CYCLES + 1);

    typedef logic [BYTE_W-1:0]       scan_byte_t;
    typedef logic [FIFO_PTR_W-1:0]   fifo_ptr_t;
    typedef logic [FIFO_PTR_W:0]     fifo_count_t;
    typedef logic [FILTER_CNT_W-1:0] filter_cnt_t;
    typedef logic [STALL_CNT_W-1:0]  stall_cnt_t;
    typedef logic [2:0]              bit_idx_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DATA,
        ST_PARITY,
        ST_STOP
    } frame_state_t;

    // One filtered device clock edge and the data level seen with it.
    typedef struct packed {
        logic fall_stb;
        logic bit_val;
    } line_sample_t;

endpackage
